/* include/qmap_config.svh */
`ifndef QMAP_CONFIG_SVH
`define QMAP_CONFIG_SVH

// ----------------------------------------
// lane and stream geometry
// ----------------------------------------
`define QMAP_NUM_LANES  4
`define QMAP_LANE_W     2
`define QMAP_DATA_BYTES 8
`define QMAP_DATA_W     (`QMAP_DATA_BYTES * 8)

// ----------------------------------------
// queue tables
// ----------------------------------------
// one table per host interface, indexed by the low entropy bits
`define QMAP_NUM_HOSTS  4
`define QMAP_TBL_DEPTH  128
`define QMAP_IDX_W      7
`define QMAP_QID_W      12

`endif

/* source/qmap_pkg.sv */
`include "qmap_config.svh"

package qmap_pkg;

    // host interface, taken from the top two entropy bits
    typedef enum logic [1:0] {
        PF  = 2'd0,
        VF0 = 2'd1,
        VF1 = 2'd2,
        VF2 = 2'd3
    } host_if_e;

    // config write opcode
    typedef enum logic {
        CFG_ENTRY = 1'b0,
        CFG_BASE  = 1'b1
    } cfg_sel_e;

    // merger state
    typedef enum logic {
        ARB_IDLE = 1'b0,
        ARB_PKT  = 1'b1
    } arb_state_e;

    // ----------------------------------------
    // stream beat
    // ----------------------------------------
    typedef struct packed {
        logic [`QMAP_LANE_W-1:0] src_lane;
        logic                    rss_enable;
        logic [`QMAP_QID_W-1:0]  rss_entropy;
    } stream_meta_t;

    typedef struct packed {
        logic [`QMAP_DATA_W-1:0]     data;
        logic [`QMAP_DATA_BYTES-1:0] keep;
        logic                        last;
        stream_meta_t                meta;
    } stream_beat_t;

    // ----------------------------------------
    // config path
    // ----------------------------------------
    typedef struct packed {
        cfg_sel_e               sel;
        host_if_e               host;
        logic [`QMAP_IDX_W-1:0] idx;
        logic [`QMAP_QID_W-1:0] value;
    } cfg_req_t;

    // tables and bases, indexed by host_if_e
    typedef struct packed {
        logic [`QMAP_NUM_HOSTS-1:0][`QMAP_TBL_DEPTH-1:0][`QMAP_QID_W-1:0] tbl;
        logic [`QMAP_NUM_HOSTS-1:0][`QMAP_QID_W-1:0]                      base;
    } qmap_tables_t;

endpackage

/* source/qmap_table_regs.sv */
`timescale 1ns/1ps

module qmap_table_regs (
    input  logic                   core_clk,
    input  logic                   rst,
    input  logic                   cfg_wr,
    input  qmap_pkg::cfg_req_t     cfg_req,
    output qmap_pkg::qmap_tables_t tables
);
    import qmap_pkg::*;

    // ----------------------------------------
    // write decode
    // ----------------------------------------
    logic entry_wr;
    logic base_wr;

    always_comb begin
        entry_wr = 1'b0;
        base_wr  = 1'b0;
        if (cfg_wr) begin
            case (cfg_req.sel)
                CFG_ENTRY: entry_wr = 1'b1;
                CFG_BASE:  base_wr  = 1'b1;
                default:   ;
            endcase
        end
    end

    // ----------------------------------------
    // storage
    // ----------------------------------------
    qmap_tables_t tables_q;

    always_ff @(posedge core_clk) begin
        if (rst) begin
            tables_q <= '0;
        end else begin
            // one entry of the selected host table
            if (entry_wr) begin
                tables_q.tbl[cfg_req.host][cfg_req.idx] <= cfg_req.value;
            end
            // queue base of the selected host
            if (base_wr) begin
                tables_q.base[cfg_req.host] <= cfg_req.value;
            end
        end
    end

    // new values visible from the cycle after the strobe
    assign tables = tables_q;

endmodule

/* source/hash2qid_lane.sv */
`timescale 1ns/1ps

`include "qmap_config.svh"

module hash2qid_lane (
    input  logic                   core_clk,
    input  logic                   rst,
    input  qmap_pkg::qmap_tables_t tables,
    input  logic                   in_valid,
    output logic                   in_ready,
    input  qmap_pkg::stream_beat_t in_beat,
    output logic                   out_valid,
    input  logic                   out_ready,
    output qmap_pkg::stream_beat_t out_beat
);
    import qmap_pkg::*;

    // stage occupancy and advance
    logic s1_valid, s2_valid, s3_valid;
    logic adv1, adv2, adv3;

    // a stage moves when empty or when the next one moves
    assign adv3     = !s3_valid || out_ready;
    assign adv2     = !s2_valid || adv3;
    assign adv1     = !s1_valid || adv2;
    assign in_ready = adv1;

    always_ff @(posedge core_clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            s3_valid <= 1'b0;
        end else begin
            if (adv1) s1_valid <= in_valid;
            if (adv2) s2_valid <= s1_valid;
            if (adv3) s3_valid <= s2_valid;
        end
    end

    // ----------------------------------------
    // stage 1: latch beat, read all tables
    // ----------------------------------------
    stream_beat_t                                s1_beat;
    logic [`QMAP_NUM_HOSTS-1:0][`QMAP_QID_W-1:0] s1_hits;

    always_ff @(posedge core_clk) begin
        if (adv1) begin
            s1_beat <= in_beat;
            for (int h = 0; h < `QMAP_NUM_HOSTS; h++) begin
                s1_hits[h] <= tables.tbl[h][in_beat.meta.rss_entropy[`QMAP_IDX_W-1:0]];
            end
        end
    end

    // ----------------------------------------
    // stage 2: host select and base
    // ----------------------------------------
    host_if_e               s1_host;
    stream_beat_t           s2_beat;
    logic [`QMAP_QID_W-1:0] s2_qid;
    logic [`QMAP_QID_W-1:0] s2_base;

    assign s1_host = host_if_e'(s1_beat.meta.rss_entropy[`QMAP_QID_W-1 -: 2]);

    always_ff @(posedge core_clk) begin
        if (adv2) begin
            s2_beat <= s1_beat;
            s2_base <= tables.base[s1_host];
            if (!s1_beat.meta.rss_enable) begin
                s2_qid <= '0;
            end else begin
                case (s1_host)
                    PF:      s2_qid <= s1_hits[PF];
                    VF0:     s2_qid <= s1_hits[VF0];
                    VF1:     s2_qid <= s1_hits[VF1];
                    VF2:     s2_qid <= s1_hits[VF2];
                    default: s2_qid <= '0;
                endcase
            end
        end
    end

    // ----------------------------------------
    // stage 3: add, wraps at queue id width
    // ----------------------------------------
    stream_beat_t           s3_beat;
    logic [`QMAP_QID_W-1:0] s3_qid;

    always_ff @(posedge core_clk) begin
        if (adv3) begin
            s3_beat <= s2_beat;
            s3_qid  <= s2_qid + s2_base;
        end
    end

    // queue id replaces entropy, rss always flagged on
    always_comb begin
        out_beat                  = s3_beat;
        out_beat.meta.rss_entropy = s3_qid;
        out_beat.meta.rss_enable  = 1'b1;
    end

    assign out_valid = s3_valid;

endmodule

/* source/lane_merge_arb.sv */
`timescale 1ns/1ps

`include "qmap_config.svh"

module lane_merge_arb (
    input  logic                   core_clk,
    input  logic                   rst,
    input  logic                   lane_valid [`QMAP_NUM_LANES],
    output logic                   lane_ready [`QMAP_NUM_LANES],
    input  qmap_pkg::stream_beat_t lane_beat  [`QMAP_NUM_LANES],
    output logic                   out_valid,
    input  logic                   out_ready,
    output qmap_pkg::stream_beat_t out_beat
);
    import qmap_pkg::*;

    arb_state_e              state;
    logic [`QMAP_LANE_W-1:0] ptr;
    logic [`QMAP_LANE_W-1:0] cur;

    // ----------------------------------------
    // round-robin search from ptr
    // ----------------------------------------
    logic                    found;
    logic [`QMAP_LANE_W-1:0] pick;
    logic [`QMAP_LANE_W-1:0] probe;

    always_comb begin
        found = 1'b0;
        pick  = ptr;
        probe = ptr;
        for (int i = 0; i < `QMAP_NUM_LANES; i++) begin
            probe = ptr + `QMAP_LANE_W'(i);
            if (!found && lane_valid[probe]) begin
                found = 1'b1;
                pick  = probe;
            end
        end
    end

    // grant is combinational in idle, held once a packet starts
    logic                    active;
    logic [`QMAP_LANE_W-1:0] grant;
    logic                    xfer;

    assign active    = (state == ARB_PKT) || found;
    assign grant     = (state == ARB_PKT) ? cur : pick;
    assign out_valid = active && lane_valid[grant];
    assign xfer      = out_valid && out_ready;

    always_comb begin
        out_beat               = lane_beat[grant];
        out_beat.meta.src_lane = grant;
        for (int i = 0; i < `QMAP_NUM_LANES; i++) begin
            lane_ready[i] = active && (grant == `QMAP_LANE_W'(i)) && out_ready;
        end
    end

    // ----------------------------------------
    // state
    // ----------------------------------------
    always_ff @(posedge core_clk) begin
        if (rst) begin
            state <= ARB_IDLE;
            ptr   <= '0;
            cur   <= '0;
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (found) begin
                        ptr <= pick + 1'b1;
                        cur <= pick;
                        // lock unless a single-beat packet went straight out
                        if (!(xfer && out_beat.last)) state <= ARB_PKT;
                    end
                end
                ARB_PKT: begin
                    if (xfer && out_beat.last) state <= ARB_IDLE;
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

endmodule

/* source/qmap_top.sv */
`timescale 1ns/1ps

`include "qmap_config.svh"

module qmap_top (
    input  logic                   core_clk,
    input  logic                   rst,
    input  logic                   cfg_wr,
    input  qmap_pkg::cfg_req_t     cfg_req,
    input  logic                   in_valid [`QMAP_NUM_LANES],
    output logic                   in_ready [`QMAP_NUM_LANES],
    input  qmap_pkg::stream_beat_t in_beat  [`QMAP_NUM_LANES],
    output logic                   out_valid,
    input  logic                   out_ready,
    output qmap_pkg::stream_beat_t out_beat
);
    import qmap_pkg::*;

    qmap_tables_t tables;

    // lane outputs into the merger
    logic         lane_valid [`QMAP_NUM_LANES];
    logic         lane_ready [`QMAP_NUM_LANES];
    stream_beat_t lane_beat  [`QMAP_NUM_LANES];

    qmap_table_regs u_table_regs (
        .core_clk (core_clk),
        .rst      (rst),
        .cfg_wr   (cfg_wr),
        .cfg_req  (cfg_req),
        .tables   (tables)
    );

    // ----------------------------------------
    // one pipeline per lane
    // ----------------------------------------
    for (genvar g = 0; g < `QMAP_NUM_LANES; g++) begin : g_lane
        hash2qid_lane u_lane (
            .core_clk  (core_clk),
            .rst       (rst),
            .tables    (tables),
            .in_valid  (in_valid[g]),
            .in_ready  (in_ready[g]),
            .in_beat   (in_beat[g]),
            .out_valid (lane_valid[g]),
            .out_ready (lane_ready[g]),
            .out_beat  (lane_beat[g])
        );
    end

    lane_merge_arb u_merge (
        .core_clk   (core_clk),
        .rst        (rst),
        .lane_valid (lane_valid),
        .lane_ready (lane_ready),
        .lane_beat  (lane_beat),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_beat   (out_beat)
    );

endmodule

/* tb/qmap_chk.sv */
`timescale 1ns/1ps

`include "qmap_config.svh"

module qmap_chk (
    input logic                   core_clk,
    input logic                   rst,
    input logic                   out_valid,
    input logic                   out_ready,
    input qmap_pkg::stream_beat_t out_beat
);
    import qmap_pkg::*;

    int                      fails;
    logic                    pkt_open;
    logic [`QMAP_LANE_W-1:0] pkt_lane;

    // lane of the packet currently on the output
    always @(posedge core_clk) begin
        if (rst) begin
            pkt_open <= 1'b0;
        end else if (out_valid && out_ready) begin
            pkt_open <= !out_beat.last;
            pkt_lane <= out_beat.meta.src_lane;
        end
    end

    quiet_in_reset: assert property (@(posedge core_clk) rst |=> !out_valid)
        else begin
            fails++;
            $error("out_valid high during reset");
        end

    hold_while_stalled: assert property (@(posedge core_clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_beat))
        else begin
            fails++;
            $error("out_beat changed or out_valid dropped while stalled");
        end

    one_lane_per_pkt: assert property (@(posedge core_clk) disable iff (rst)
        out_valid && pkt_open |-> out_beat.meta.src_lane == pkt_lane)
        else begin
            fails++;
            $error("source lane changed inside a packet");
        end

endmodule

bind qmap_top qmap_chk u_chk (
    .core_clk  (core_clk),
    .rst       (rst),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_beat  (out_beat)
);

/* tb/qmap_scoreboard.sv */
`timescale 1ns/1ps

`include "qmap_config.svh"

module qmap_scoreboard (
    input  logic                   core_clk,
    input  logic                   rst,
    input  logic                   cfg_wr,
    input  qmap_pkg::cfg_req_t     cfg_req,
    input  logic                   in_valid [`QMAP_NUM_LANES],
    input  logic                   in_ready [`QMAP_NUM_LANES],
    input  qmap_pkg::stream_beat_t in_beat  [`QMAP_NUM_LANES],
    input  logic                   out_valid,
    input  logic                   out_ready,
    input  qmap_pkg::stream_beat_t out_beat,
    output int                     value_errs,
    output int                     flow_errs,
    output int                     out_total
);
    import qmap_pkg::*;

    // own copy of the queue tables, built from the config writes
    logic [`QMAP_QID_W-1:0]  tbl  [`QMAP_NUM_HOSTS][`QMAP_TBL_DEPTH];
    logic [`QMAP_QID_W-1:0]  base [`QMAP_NUM_HOSTS];
    stream_beat_t            want_q  [`QMAP_NUM_LANES][$];
    int                      in_cnt  [`QMAP_NUM_LANES];
    int                      out_cnt [`QMAP_NUM_LANES];
    int                      in_total;
    logic                    pkt_open;
    logic [`QMAP_LANE_W-1:0] pkt_lane;

    function automatic stream_beat_t expected_beat(input stream_beat_t b, input int ln);
        stream_beat_t           r;
        int                     host;
        logic [`QMAP_QID_W-1:0] entry;
        host  = int'(b.meta.rss_entropy[`QMAP_QID_W-1 -: 2]);
        entry = '0;
        if (b.meta.rss_enable) begin
            entry = tbl[host][b.meta.rss_entropy[`QMAP_IDX_W-1:0]];
        end
        r                  = b;
        // sum kept to 12 bits, so it wraps at 4096
        r.meta.rss_entropy = entry + base[host];
        r.meta.rss_enable  = 1'b1;
        r.meta.src_lane    = `QMAP_LANE_W'(ln);
        return r;
    endfunction

    task automatic check_out();
        stream_beat_t want;
        int           ln;
        ln = int'(out_beat.meta.src_lane);
        out_total++;
        out_cnt[ln]++;
        if (pkt_open && out_beat.meta.src_lane != pkt_lane) begin
            flow_errs++;
            $display("%0t: lane %0d beat cut into open packet of lane %0d", $time, ln, pkt_lane);
        end
        pkt_open = !out_beat.last;
        pkt_lane = out_beat.meta.src_lane;
        if (want_q[ln].size() == 0) begin
            flow_errs++;
            $display("%0t: beat out for lane %0d that was never sent in", $time, ln);
        end else begin
            want = want_q[ln].pop_front();
            if (out_beat !== want) begin
                value_errs++;
                $display("FAIL t=%0t out_beat lane %0d: expected %h, actual %h",
                         $time, ln, want, out_beat);
            end
        end
    endtask

    // every lane drained, beats in equal beats out
    task automatic final_check();
        for (int l = 0; l < `QMAP_NUM_LANES; l++) begin
            if (out_cnt[l] != in_cnt[l]) begin
                value_errs++;
                $display("FAIL t=%0t out_cnt lane %0d: expected %0d, actual %0d",
                         $time, l, in_cnt[l], out_cnt[l]);
            end
        end
    endtask

    // sampled mid-cycle, a handshake seen here completes at the next edge
    always @(negedge core_clk) begin
        if (rst) begin
            foreach (tbl[h, i]) tbl[h][i] = '0;
            foreach (base[h]) base[h] = '0;
            pkt_open = 1'b0;
        end else begin
            if (cfg_wr && cfg_req.sel == CFG_ENTRY) tbl[cfg_req.host][cfg_req.idx] = cfg_req.value;
            if (cfg_wr && cfg_req.sel == CFG_BASE) base[cfg_req.host] = cfg_req.value;
            for (int l = 0; l < `QMAP_NUM_LANES; l++) begin
                if (in_valid[l] && in_ready[l]) begin
                    want_q[l].push_back(expected_beat(in_beat[l], l));
                    in_cnt[l]++;
                    in_total++;
                end
            end
            if (out_valid && in_total == 0) begin
                flow_errs++;
                $display("%0t: out_valid high before any input was taken", $time);
            end
            if (out_valid && out_ready) check_out();
        end
    end

endmodule

/* tb/qmap_tb.sv */
`timescale 1ns/1ps

`include "qmap_config.svh"

module qmap_tb;
    import qmap_pkg::*;

    localparam int PKTS        = 60;
    // longest case is six beats per packet on every lane
    localparam int TIMEOUT_CYC = PKTS * 6 * `QMAP_NUM_LANES * 8 + 600;

    logic         core_clk;
    logic         rst;
    logic         cfg_wr;
    cfg_req_t     cfg_req;
    logic         in_valid [`QMAP_NUM_LANES];
    logic         in_ready [`QMAP_NUM_LANES];
    stream_beat_t in_beat  [`QMAP_NUM_LANES];
    logic         out_valid;
    logic         out_ready;
    stream_beat_t out_beat;
    int           value_errs;
    int           flow_errs;
    int           out_total;
    int           sent_total;

    qmap_top UUT (.*);

    qmap_scoreboard sb (.*);

    initial begin
        core_clk = 1'b0;
        forever #20 core_clk = ~core_clk;
    end

    initial begin
        repeat (TIMEOUT_CYC) @(posedge core_clk);
        $display("run timed out after %0d cycles with %0d of %0d beats out",
                 TIMEOUT_CYC, out_total, sent_total);
        $display("tests failed");
        $finish;
    end

    // ----------------------------------------
    // stimulus tasks
    // ----------------------------------------
    task automatic write_cfg(input cfg_sel_e sel, input int host, input int idx);
        cfg_req.sel   = sel;
        cfg_req.host  = host_if_e'(host);
        cfg_req.idx   = `QMAP_IDX_W'(idx);
        cfg_req.value = `QMAP_QID_W'($urandom);
        cfg_wr        = 1'b1;
        @(posedge core_clk);
        #2;
    endtask

    task automatic drive_ready();
        forever begin
            @(posedge core_clk);
            #2;
            out_ready = ($urandom_range(9) < 7);
        end
    endtask

    task automatic send_lane(input int ln);
        stream_beat_t b;
        int           len;
        logic         took;
        for (int p = 0; p < PKTS; p++) begin
            len = 1 + $urandom_range(5);
            for (int k = 0; k < len; k++) begin
                b.data             = {$urandom, $urandom};
                b.keep             = `QMAP_DATA_BYTES'($urandom);
                b.last             = (k == len - 1);
                b.meta.rss_entropy = `QMAP_QID_W'($urandom);
                b.meta.rss_enable  = ($urandom_range(99) < 80);
                // lanes must ignore whatever comes in here
                b.meta.src_lane    = `QMAP_LANE_W'($urandom);
                in_beat[ln]        = b;
                in_valid[ln]       = 1'b1;
                do begin
                    @(negedge core_clk);
                    took = in_ready[ln];
                    @(posedge core_clk);
                    #2;
                end while (!took);
                in_valid[ln] = 1'b0;
                sent_total++;
                if ($urandom_range(3) == 0) begin
                    repeat ($urandom_range(3, 1)) @(posedge core_clk);
                    #2;
                end
            end
        end
    endtask

    // ----------------------------------------
    // main sequence
    // ----------------------------------------
    initial begin
        void'($urandom(32'hdaaa_c70b));
        rst       = 1'b1;
        cfg_wr    = 1'b0;
        cfg_req   = '0;
        out_ready = 1'b0;
        for (int l = 0; l < `QMAP_NUM_LANES; l++) begin
            in_valid[l] = 1'b0;
            in_beat[l]  = '0;
        end
        fork
            drive_ready();
        join_none
        repeat (16) @(posedge core_clk);
        #2;
        rst = 1'b0;

        for (int h = 0; h < `QMAP_NUM_HOSTS; h++) begin
            for (int i = 0; i < `QMAP_TBL_DEPTH; i++) write_cfg(CFG_ENTRY, h, i);
        end
        for (int h = 0; h < `QMAP_NUM_HOSTS; h++) write_cfg(CFG_BASE, h, 0);
        cfg_wr = 1'b0;

        fork
            begin
                for (int l = 0; l < `QMAP_NUM_LANES; l++) begin
                    fork
                        automatic int ln = l;
                        send_lane(ln);
                    join_none
                end
                wait fork;
            end
        join

        wait (out_total == sent_total);
        repeat (8) @(posedge core_clk);
        sb.final_check();
        $display("errors: %0d value, %0d flow, %0d assertion (%0d beats checked)",
                 value_errs, flow_errs, UUT.u_chk.fails, out_total);
        if (value_errs + flow_errs + UUT.u_chk.fails == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* sim.f */
+incdir+include
source/qmap_pkg.sv
source/qmap_table_regs.sv
source/hash2qid_lane.sv
source/lane_merge_arb.sv
source/qmap_top.sv
tb/qmap_chk.sv
tb/qmap_scoreboard.sv
tb/qmap_tb.sv
